//--- hw/ccx_arb_pkg.sv
`include "ccx_macros.svh"

package ccx_arb_pkg;

  // One bit per core
  typedef logic [`CCX_NUM_SRC-1:0] src_mask_t;

  // One bit per bank, also the per-core grant bus
  typedef logic [`CCX_NUM_DST-1:0] dst_mask_t;

  // Queue heads of all cores for one bank
  typedef ccx_pcx_pkg::pcx_pkt_t [`CCX_NUM_SRC-1:0] src_pkt_arr_t;

endpackage

//--- hw/ccx_macros.svh
`ifndef CCX_MACROS_SVH
`define CCX_MACROS_SVH

// Crossbar sizing for the PCX path

// Number of cores driving requests
`define CCX_NUM_SRC 4

// Number of cache banks receiving packets
`define CCX_NUM_DST 4

`define CCX_ADDR_W 16 // Request address bits
`define CCX_DATA_W 32 // Store data bits

// Entries in every ingress and egress queue
// Also the per-bank credit count of each core
`define CCX_QDEPTH 2

`endif

//--- hw/ccx_pcx.sv
`timescale 1ns/1ps
`include "ccx_macros.svh"

module ccx_pcx (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  ccx_pcx_pkg::pcx_req_t     spc_req        [`CCX_NUM_SRC],
  output ccx_arb_pkg::dst_mask_t    spc_grant      [`CCX_NUM_SRC], // Per core, bit per bank
  output ccx_pcx_pkg::pcx_dst_pkt_t sctag_data     [`CCX_NUM_DST],
  output ccx_arb_pkg::dst_mask_t    sctag_data_rdy,
  input  ccx_arb_pkg::dst_mask_t    sctag_stall
);

  import ccx_pcx_pkg::*;
  import ccx_arb_pkg::*;

  localparam int NUM_SRC = `CCX_NUM_SRC;
  localparam int NUM_DST = `CCX_NUM_DST;

  src_mask_t    head_valid [NUM_DST]; // Ingress to arbiters
  src_pkt_arr_t head_pkt   [NUM_DST];
  src_mask_t    arb_pop    [NUM_DST]; // Arbiters back to ingress
  src_mask_t    bank_grant [NUM_DST]; // Grant as seen by each bank
  dst_mask_t    eg_push;
  dst_mask_t    eg_full;
  pcx_dst_pkt_t eg_pkt     [NUM_DST];

  ccx_pcx_ingress u_ingress (
    .rclk       (rclk),
    .rst_n      (rst_n),
    .spc_req    (spc_req),
    .pop        (arb_pop),
    .head_valid (head_valid),
    .head_pkt   (head_pkt)
  );

  for (genvar d = 0; d < NUM_DST; d++) begin : g_arb
    ccx_rr_arb u_arb (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .head_valid (head_valid[d]),
      .head_pkt   (head_pkt[d]),
      .out_full   (eg_full[d]),
      .pop        (arb_pop[d]),
      .push       (eg_push[d]),
      .push_pkt   (eg_pkt[d]),
      .grant      (bank_grant[d])
    );
  end

  ccx_pcx_egress u_egress (
    .rclk           (rclk),
    .rst_n          (rst_n),
    .push           (eg_push),
    .push_pkt       (eg_pkt),
    .sctag_stall    (sctag_stall),
    .full           (eg_full),
    .sctag_data     (sctag_data),
    .sctag_data_rdy (sctag_data_rdy)
  );

  // Bank-major grants turned into core-major buses
  for (genvar s = 0; s < NUM_SRC; s++) begin : g_gnt_src
    for (genvar d = 0; d < NUM_DST; d++) begin : g_gnt_dst
      assign spc_grant[s][d] = bank_grant[d][s];
    end
  end

endmodule

//--- hw/ccx_pcx_egress.sv
`timescale 1ns/1ps
`include "ccx_macros.svh"

module ccx_pcx_egress (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  ccx_arb_pkg::dst_mask_t    push,         // From arbiters
  input  ccx_pcx_pkg::pcx_dst_pkt_t push_pkt       [`CCX_NUM_DST],
  input  ccx_arb_pkg::dst_mask_t    sctag_stall,  // Bank back-pressure
  output ccx_arb_pkg::dst_mask_t    full,
  output ccx_pcx_pkg::pcx_dst_pkt_t sctag_data     [`CCX_NUM_DST],
  output ccx_arb_pkg::dst_mask_t    sctag_data_rdy
);

  import ccx_pcx_pkg::*;
  import ccx_arb_pkg::*;

  localparam int NUM_DST = `CCX_NUM_DST;

  dst_mask_t bank_pop; // Packet consumed by bank

  // Held packet stays on sctag_data until the stall drops
  assign bank_pop = sctag_data_rdy & ~sctag_stall;

  for (genvar d = 0; d < NUM_DST; d++) begin : g_bank
    ccx_pkt_fifo #(
      .payload_t (pcx_dst_pkt_t),
      .DEPTH     (`CCX_QDEPTH)
    ) u_q (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .push      (push[d]),
      .push_data (push_pkt[d]),
      .pop       (bank_pop[d]),
      .head      (sctag_data[d]),
      .not_empty (sctag_data_rdy[d]), // Valid whenever data held
      .full      (full[d])            // Stalls the arbiter
    );
  end

endmodule

//--- hw/ccx_pcx_ingress.sv
`timescale 1ns/1ps
`include "ccx_macros.svh"

module ccx_pcx_ingress (
  input  logic                       rclk,
  input  logic                       rst_n,
  input  ccx_pcx_pkg::pcx_req_t      spc_req    [`CCX_NUM_SRC], // Per core
  input  ccx_arb_pkg::src_mask_t     pop        [`CCX_NUM_DST], // Per bank
  output ccx_arb_pkg::src_mask_t     head_valid [`CCX_NUM_DST],
  output ccx_arb_pkg::src_pkt_arr_t  head_pkt   [`CCX_NUM_DST]
);

  import ccx_pcx_pkg::*;

  localparam int NUM_SRC = `CCX_NUM_SRC;
  localparam int NUM_DST = `CCX_NUM_DST;

  // One queue per core and bank pair, so a busy bank never blocks another
  for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
    for (genvar d = 0; d < NUM_DST; d++) begin : g_dst
      logic q_push; // Request targets this bank

      assign q_push = spc_req[s].valid && (spc_req[s].dst == dst_id_t'(d));

      // Credit rule keeps these from overflowing, full is not needed
      ccx_pkt_fifo #(
        .payload_t (pcx_pkt_t),
        .DEPTH     (`CCX_QDEPTH)
      ) u_q (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .push      (q_push),
        .push_data (spc_req[s].pkt),
        .pop       (pop[d][s]),        // From bank d arbiter
        .head      (head_pkt[d][s]),   // Gathered by bank
        .not_empty (head_valid[d][s]),
        .full      ()
      );
    end
  end

endmodule

//--- hw/ccx_pcx_pkg.sv
`include "ccx_macros.svh"

package ccx_pcx_pkg;

  typedef enum logic [1:0] {
    PCX_LOAD  = 2'd0, // Cache line read
    PCX_STORE = 2'd1, // Write with data
    PCX_IFILL = 2'd2  // Instruction fetch
  } pcx_rqtype_e;

  typedef logic [$clog2(`CCX_NUM_SRC)-1:0] src_id_t; // Core number
  typedef logic [$clog2(`CCX_NUM_DST)-1:0] dst_id_t; // Bank number

  // Packet body, 50 bits with default widths
  typedef struct packed {
    pcx_rqtype_e             rqtype;
    logic [`CCX_ADDR_W-1:0]  addr;
    logic [`CCX_DATA_W-1:0]  data;
  } pcx_pkt_t;

  typedef struct packed {
    logic     valid; // Request this cycle
    dst_id_t  dst;   // Target bank
    pcx_pkt_t pkt;
  } pcx_req_t;

  typedef struct packed {
    src_id_t  src; // Originating core
    pcx_pkt_t pkt;
  } pcx_dst_pkt_t;

endpackage

//--- hw/ccx_pkt_fifo.sv
`timescale 1ns/1ps

module ccx_pkt_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     rclk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH]; // Entry storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;      // Entries held
  logic             do_push;
  logic             do_pop;

  assign do_push   = push && !full; // Drop on overflow
  assign do_pop    = pop && not_empty;
  assign full      = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr]; // Oldest entry, read through

  always_ff @(posedge rclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge rclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop); // Net change
    end
  end

endmodule

//--- hw/ccx_rr_arb.sv
`timescale 1ns/1ps
`include "ccx_macros.svh"

module ccx_rr_arb (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  ccx_arb_pkg::src_mask_t    head_valid, // Non-empty queues
  input  ccx_arb_pkg::src_pkt_arr_t head_pkt,
  input  logic                      out_full,   // Egress cannot take more
  output ccx_arb_pkg::src_mask_t    pop,
  output logic                      push,
  output ccx_pcx_pkg::pcx_dst_pkt_t push_pkt,
  output ccx_arb_pkg::src_mask_t    grant       // Registered, one cycle
);

  import ccx_pcx_pkg::*;
  import ccx_arb_pkg::*;

  localparam int NUM_SRC = `CCX_NUM_SRC;

  src_id_t   ptr;     // Highest priority source
  src_id_t   win_id;
  logic      win_vld;
  logic      go;      // Winner moves this cycle
  src_mask_t win_oh;

  // Scan from the pointer upward, first valid wins
  always_comb begin
    src_id_t idx;
    win_vld = 1'b0;
    win_id  = ptr;
    for (int i = 0; i < NUM_SRC; i++) begin
      idx = src_id_t'((int'(ptr) + i) % NUM_SRC);
      if (!win_vld && head_valid[idx]) begin
        win_vld = 1'b1;
        win_id  = idx;
      end
    end
  end

  assign go       = win_vld && !out_full; // Hold off on full egress
  assign win_oh   = src_mask_t'(1) << win_id;
  assign pop      = go ? win_oh : '0;
  assign push     = go;
  assign push_pkt = '{src: win_id, pkt: head_pkt[win_id]}; // Tag with source

  always_ff @(posedge rclk) begin
    if (!rst_n) begin
      ptr   <= '0; // Source 0 first
      grant <= '0;
    end else begin
      grant <= pop; // Credit back to the winner
      if (go) begin
        ptr <= src_id_t'((int'(win_id) + 1) % NUM_SRC); // One past winner
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" \
  && verilator --binary --timing -f src.f --top-module tb_ccx_pcx -Mdir obj_dir \
  && ./obj_dir/Vtb_ccx_pcx | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- src.f
+incdir+hw
hw/ccx_pcx_pkg.sv
hw/ccx_arb_pkg.sv
hw/ccx_pkt_fifo.sv
hw/ccx_pcx_ingress.sv
hw/ccx_rr_arb.sv
hw/ccx_pcx_egress.sv
hw/ccx_pcx.sv
tests/tb_ccx_pcx.sv

//--- tests/tb_ccx_pcx.sv
`timescale 1ns/1ps
`include "ccx_macros.svh"

module tb_ccx_pcx;

  import ccx_pcx_pkg::*;
  import ccx_arb_pkg::*;

  localparam int NUM_SRC = `CCX_NUM_SRC;
  localparam int NUM_DST = `CCX_NUM_DST;
  localparam int QDEPTH  = `CCX_QDEPTH;

  logic         rclk;
  logic         rst_n;
  pcx_req_t     spc_req        [NUM_SRC];
  dst_mask_t    spc_grant      [NUM_SRC];
  pcx_dst_pkt_t sctag_data     [NUM_DST];
  dst_mask_t    sctag_data_rdy;
  dst_mask_t    sctag_stall;

  int           cycle;                       // Rising edges so far
  int           errors;
  int           timeouts;
  int unsigned  lcg_state = 12;
  string        test_name;
  int           req_edge;                    // Edge that samples the last request
  dst_id_t      tx_dst  [NUM_SRC];
  pcx_pkt_t     tx_pkt  [NUM_SRC];
  pcx_dst_pkt_t rx_pkt  [NUM_DST][$];        // Packets taken by each bank
  int           rx_cyc  [NUM_DST][$];
  int           gnt_cnt [NUM_SRC][NUM_DST];
  int           gnt_cyc [NUM_SRC][NUM_DST];  // Edge of latest grant

  ccx_pcx dut0 (
    .rclk           (rclk),
    .rst_n          (rst_n),
    .spc_req        (spc_req),
    .spc_grant      (spc_grant),
    .sctag_data     (sctag_data),
    .sctag_data_rdy (sctag_data_rdy),
    .sctag_stall    (sctag_stall)
  );

  initial begin
    rclk = 1'b0;
    forever #4 rclk = ~rclk; // 8 ns period
  end

  always @(posedge rclk) begin
    cycle <= cycle + 1;
  end

  // Bank side monitor sampled mid-cycle where outputs are settled
  always @(negedge rclk) begin
    if (rst_n) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        for (int d = 0; d < NUM_DST; d++) begin
          if (spc_grant[s][d]) begin
            gnt_cnt[s][d] = gnt_cnt[s][d] + 1;
            gnt_cyc[s][d] = cycle;
          end
        end
      end
      for (int d = 0; d < NUM_DST; d++) begin
        if (sctag_data_rdy[d] && !sctag_stall[d]) begin // Consumed at next edge
          rx_pkt[d].push_back(sctag_data[d]);
          rx_cyc[d].push_back(cycle);
        end
      end
    end
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pcx_pkt_t rand_pkt();
    pcx_pkt_t p;
    p.rqtype = pcx_rqtype_e'(2'((next_rand() >> 16) % 3)); // Load, store or ifill
    p.addr   = `CCX_ADDR_W'(next_rand() >> 8);
    p.data   = `CCX_DATA_W'(next_rand());
    return p;
  endfunction

  task automatic check(string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  // One request cycle with cores outside the mask idle
  task automatic drive_cycle(src_mask_t mask);
    @(posedge rclk);
    #1;
    for (int s = 0; s < NUM_SRC; s++) begin
      spc_req[s].valid = mask[s];
      spc_req[s].dst   = tx_dst[s];
      spc_req[s].pkt   = tx_pkt[s];
    end
    if (mask != '0) begin
      req_edge = cycle + 1;
    end
  endtask

  task automatic idle(int n);
    repeat (n) drive_cycle('0);
  endtask

  task automatic set_stall(dst_mask_t mask);
    @(posedge rclk);
    #1;
    sctag_stall = mask;
  endtask

  task automatic wait_rx(int d, int target, int limit);
    int n = 0;
    while (rx_pkt[d].size() < target && n < limit) begin
      @(posedge rclk);
      n++;
    end
    if (rx_pkt[d].size() < target) begin
      timeouts++;
      $display("Timeout in %s: bank %0d took %0d packets, waited for %0d",
               test_name, d, rx_pkt[d].size(), target);
    end
  endtask

  task automatic wait_rdy(int d, int limit);
    int n = 0;
    while (!sctag_data_rdy[d] && n < limit) begin
      @(posedge rclk);
      #1;
      n++;
    end
    if (!sctag_data_rdy[d]) begin
      timeouts++;
      $display("Timeout in %s: bank %0d never showed data ready", test_name, d);
    end
  endtask

  // Hold off a core until it has a free credit for the bank
  task automatic wait_credit(int s, int d, int g_base, int sent, int limit);
    int n = 0;
    while (sent - (gnt_cnt[s][d] - g_base) >= QDEPTH && n < limit) begin
      @(posedge rclk);
      #1;
      n++;
    end
    if (sent - (gnt_cnt[s][d] - g_base) >= QDEPTH) begin
      timeouts++;
      $display("Timeout in %s: core %0d got no credit back from bank %0d", test_name, s, d);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    @(negedge rclk);
    for (int s = 0; s < NUM_SRC; s++) begin
      check($sformatf("spc_grant[%0d]", s), 64'(0), 64'(spc_grant[s]));
    end
    check("sctag_data_rdy", 64'(0), 64'(sctag_data_rdy));
  endtask

  task automatic test_single();
    int base;
    int g0;
    test_name = "single";
    base      = rx_pkt[3].size();
    g0        = gnt_cnt[1][3];
    tx_dst[1] = dst_id_t'(3);
    tx_pkt[1] = rand_pkt();
    drive_cycle(src_mask_t'(2)); // Core 1 only
    drive_cycle('0);
    wait_rx(3, base + 1, 20);
    idle(3);                     // Room for a stray second grant
    check("packets", 64'(base + 1), 64'(rx_pkt[3].size()));
    check("src", 64'(1), 64'(rx_pkt[3][base].src));
    check("pkt", 64'(tx_pkt[1]), 64'(rx_pkt[3][base].pkt));
    check("arrival edge", 64'(req_edge + 1), 64'(rx_cyc[3][base]));
    check("grants", 64'(1), 64'(gnt_cnt[1][3] - g0));
    check("grant edge", 64'(req_edge + 1), 64'(gnt_cyc[1][3]));
  endtask

  task automatic test_contention();
    int base;
    test_name = "contention";
    for (int r = 0; r < 2; r++) begin // Round 2 starts once core 3 won
      base = rx_pkt[2].size();
      for (int s = 0; s < NUM_SRC; s++) begin
        tx_dst[s] = dst_id_t'(2);
        tx_pkt[s] = rand_pkt();
      end
      drive_cycle('1);
      drive_cycle('0);
      wait_rx(2, base + NUM_SRC, 40);
      for (int s = 0; s < NUM_SRC; s++) begin
        check($sformatf("round %0d slot %0d src", r, s), 64'(s), 64'(rx_pkt[2][base + s].src));
        check($sformatf("round %0d slot %0d pkt", r, s), 64'(tx_pkt[s]),
              64'(rx_pkt[2][base + s].pkt));
      end
    end
  endtask

  task automatic test_spread();
    int base [NUM_DST];
    int d;
    test_name = "spread";
    for (int s = 0; s < NUM_SRC; s++) begin
      d         = (s + 1) % NUM_DST; // Every core to another bank
      tx_dst[s] = dst_id_t'(d);
      tx_pkt[s] = rand_pkt();
      base[d]   = rx_pkt[d].size();
    end
    drive_cycle('1);
    drive_cycle('0);
    for (int s = 0; s < NUM_SRC; s++) begin
      d = (s + 1) % NUM_DST;
      wait_rx(d, base[d] + 1, 20);
      check($sformatf("bank %0d src", d), 64'(s), 64'(rx_pkt[d][base[d]].src));
      check($sformatf("bank %0d pkt", d), 64'(tx_pkt[s]), 64'(rx_pkt[d][base[d]].pkt));
      check($sformatf("bank %0d edge", d), 64'(req_edge + 1), 64'(rx_cyc[d][base[d]]));
    end
  endtask

  task automatic test_stall();
    int           base;
    int           src;
    int           g_stall;
    int           g0      [NUM_SRC];
    int           sent    [NUM_SRC];
    int           seen    [NUM_SRC];
    pcx_pkt_t     exp_pkt [NUM_SRC][QDEPTH];
    pcx_dst_pkt_t held;
    pcx_dst_pkt_t got;
    test_name = "stall";
    base      = rx_pkt[0].size();
    for (int s = 0; s < NUM_SRC; s++) begin
      g0[s]   = gnt_cnt[s][0];
      sent[s] = 0;
      seen[s] = 0;
    end
    set_stall(dst_mask_t'(1));
    for (int k = 0; k < QDEPTH; k++) begin
      for (int s = 0; s < NUM_SRC; s++) begin
        wait_credit(s, 0, g0[s], sent[s], 40);
        tx_dst[s]     = '0;
        tx_pkt[s]     = rand_pkt();
        exp_pkt[s][k] = tx_pkt[s];
        sent[s]++;
      end
      drive_cycle('1);
    end
    drive_cycle('0);
    wait_rdy(0, 20);
    held = sctag_data[0];
    check("held src", 64'(0), 64'(held.src)); // Core 3 won bank 0 last
    check("held pkt", 64'(exp_pkt[0][0]), 64'(held.pkt));
    repeat (8) begin
      @(posedge rclk);
      #1;
      check("held data", 64'(held), 64'(sctag_data[0]));
      check("held rdy", 64'(1), 64'(sctag_data_rdy[0]));
    end
    g_stall = 0;
    for (int s = 0; s < NUM_SRC; s++) begin
      g_stall += gnt_cnt[s][0] - g0[s];
    end
    check("grants while stalled", 64'(QDEPTH), 64'(g_stall)); // Full egress halts arbiter
    set_stall('0);
    wait_rx(0, base + NUM_SRC * QDEPTH, 60);
    idle(3);
    check("packets", 64'(base + NUM_SRC * QDEPTH), 64'(rx_pkt[0].size()));
    for (int i = base; i < rx_pkt[0].size(); i++) begin
      got = rx_pkt[0][i];
      src = int'(got.src);
      if (seen[src] < QDEPTH) begin
        check($sformatf("core %0d pkt %0d", src, seen[src]), 64'(exp_pkt[src][seen[src]]),
              64'(got.pkt));
      end else begin
        errors++;
        $display("Bank 0 received more packets from core %0d than it sent", src);
      end
      seen[src]++;
    end
    for (int s = 0; s < NUM_SRC; s++) begin
      check($sformatf("core %0d delivered", s), 64'(sent[s]), 64'(seen[s]));
      check($sformatf("core %0d grants", s), 64'(sent[s]), 64'(gnt_cnt[s][0] - g0[s]));
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    sctag_stall = '0;
    req_edge    = 0;
    errors      = 0;
    timeouts    = 0;
    for (int s = 0; s < NUM_SRC; s++) begin
      spc_req[s] = '0;
      tx_dst[s]  = '0;
      tx_pkt[s]  = '0;
    end
    repeat (3) @(posedge rclk); // Three reset edges
    #1;
    rst_n = 1'b1;
    test_reset();
    test_single();
    test_contention();
    test_spread();
    test_stall();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
